/* logic/forwardPkg.sv */
`default_nettype none

package forwardPkg;

    // register value and register number widths
    localparam int DataWidth    = 32;
    localparam int RegAddrWidth = 5;

    // one register value, operand or load datum
    typedef logic [DataWidth-1:0] word_t;

    // source or destination register number
    typedef logic [RegAddrWidth-1:0] regAddr_t;

    // where an operand is taken from
    typedef enum logic [2:0] {
        // value read from the register file
        srcRegFile = 3'd0,
        // ALU result of the instruction in EX
        srcEx      = 3'd1,
        // EX/MEM ALU result
        srcMem     = 3'd2,
        // load data of a load in MEM
        srcMemLoad = 3'd3,
        // MEM/WB value
        srcWb      = 3'd4,
        // register-file write port this cycle
        srcRfWrite = 3'd5
    } fwdSource_t;

endpackage

`default_nettype wire

/* logic/forwardControl.sv */
`timescale 1ns/10ps
`default_nettype none

module forwardControl
    import forwardPkg::*;
(
    input  regAddr_t   exRs,
    input  regAddr_t   exRt,
    input  logic       useImmediate,
    input  logic       isBranch,
    input  logic       isJumpReg,
    input  regAddr_t   idRs,
    input  regAddr_t   idRt,
    input  regAddr_t   exDest,
    input  logic       exWriteEnable,
    input  regAddr_t   memDest,
    input  logic       memWriteEnable,
    input  logic       memIsLoad,
    input  regAddr_t   wbDest,
    input  logic       wbWriteEnable,
    input  regAddr_t   rfDest,
    input  logic       rfWriteEnable,
    output fwdSource_t exSelA,
    output fwdSource_t exSelB,
    output fwdSource_t branchSelA,
    output fwdSource_t branchSelB,
    output fwdSource_t jumpSel
);

    // register zero and idle producers never match
    function automatic logic producerHit(
        input regAddr_t consumer,
        input regAddr_t dest,
        input logic     writeEnable
    );
        return writeEnable && (consumer != '0) && (consumer == dest);
    endfunction

    // ALU operands, youngest producer first
    function automatic fwdSource_t exPriority(
        input logic memHit,
        input logic wbHit,
        input logic rfHit
    );
        if (memHit) begin
            return srcMem;
        end else if (wbHit) begin
            return srcWb;
        end else if (rfHit) begin
            return srcRfWrite;
        end
        return srcRegFile;
    endfunction

    // ID operands also see the instruction in EX
    function automatic fwdSource_t idPriority(
        input logic exHit,
        input logic memHit,
        input logic isLoad,
        input logic wbHit,
        input logic rfHit
    );
        if (exHit) begin
            return srcEx;
        end else if (memHit) begin
            return isLoad ? srcMemLoad : srcMem;
        end else if (wbHit) begin
            return srcWb;
        end else if (rfHit) begin
            return srcRfWrite;
        end
        return srcRegFile;
    endfunction

    fwdSource_t exRtSource;
    fwdSource_t idRsSource;
    fwdSource_t idRtSource;

    // a load in MEM still gives srcMem since load-use stalls are handled upstream
    assign exSelA = exPriority(
        producerHit(exRs, memDest, memWriteEnable),
        producerHit(exRs, wbDest, wbWriteEnable),
        producerHit(exRs, rfDest, rfWriteEnable)
    );

    assign exRtSource = exPriority(
        producerHit(exRt, memDest, memWriteEnable),
        producerHit(exRt, wbDest, wbWriteEnable),
        producerHit(exRt, rfDest, rfWriteEnable)
    );

    // immediate keeps operand B
    assign exSelB = useImmediate ? srcRegFile : exRtSource;

    assign idRsSource = idPriority(
        producerHit(idRs, exDest, exWriteEnable),
        producerHit(idRs, memDest, memWriteEnable),
        memIsLoad,
        producerHit(idRs, wbDest, wbWriteEnable),
        producerHit(idRs, rfDest, rfWriteEnable)
    );

    assign idRtSource = idPriority(
        producerHit(idRt, exDest, exWriteEnable),
        producerHit(idRt, memDest, memWriteEnable),
        memIsLoad,
        producerHit(idRt, wbDest, wbWriteEnable),
        producerHit(idRt, rfDest, rfWriteEnable)
    );

    assign branchSelA = isBranch ? idRsSource : srcRegFile;
    assign branchSelB = isBranch ? idRtSource : srcRegFile;
    assign jumpSel    = isJumpReg ? idRsSource : srcRegFile;

endmodule

`default_nettype wire

/* logic/exOperandBypass.sv */
`timescale 1ns/10ps
`default_nettype none

module exOperandBypass
    import forwardPkg::*;
(
    input  logic       CLOCK,
    input  logic       RESET,
    input  fwdSource_t exSelA,
    input  fwdSource_t exSelB,
    input  word_t      exOperandA,
    input  word_t      exOperandB,
    input  word_t      memResult,
    input  word_t      wbResult,
    input  word_t      rfData,
    output word_t      exForwardedA,
    output word_t      exForwardedB,
    output logic       exForwarded
);

    // only the older producers can reach the ALU
    function automatic word_t pickOperand(
        input fwdSource_t sel,
        input word_t      regValue,
        input word_t      memValue,
        input word_t      wbValue,
        input word_t      rfValue
    );
        case (sel)
            srcMem:     return memValue;
            srcWb:      return wbValue;
            srcRfWrite: return rfValue;
            default:    return regValue;
        endcase
    endfunction

    word_t nextA;
    word_t nextB;
    logic  anyForward;

    assign nextA      = pickOperand(exSelA, exOperandA, memResult, wbResult, rfData);
    assign nextB      = pickOperand(exSelB, exOperandB, memResult, wbResult, rfData);
    assign anyForward = (exSelA != srcRegFile) || (exSelB != srcRegFile);

    always_ff @(posedge CLOCK) begin
        if (!RESET) begin
            exForwardedA <= '0;
            exForwardedB <= '0;
            exForwarded  <= 1'b0;
        end else begin
            exForwardedA <= nextA;
            exForwardedB <= nextB;
            exForwarded  <= anyForward;
        end
    end

    // EX result and raw load data are ID-stage sources only
    assert property (@(posedge CLOCK) disable iff (!RESET)
        !(exSelA inside {srcEx, srcMemLoad}) && !(exSelB inside {srcEx, srcMemLoad}))
        else $error("EX select names an ID-only source");

endmodule

`default_nettype wire

/* logic/idOperandBypass.sv */
`timescale 1ns/10ps
`default_nettype none

module idOperandBypass
    import forwardPkg::*;
(
    input  fwdSource_t branchSelA,
    input  fwdSource_t branchSelB,
    input  fwdSource_t jumpSel,
    input  word_t      idOperandA,
    input  word_t      idOperandB,
    input  word_t      exResult,
    input  word_t      memResult,
    input  word_t      memLoadData,
    input  word_t      wbResult,
    input  word_t      rfData,
    output word_t      branchOperandA,
    output word_t      branchOperandB,
    output word_t      jumpTarget,
    output logic       branchForwarded,
    output logic       jumpForwarded
);

    // full six-way pick for the ID stage
    function automatic word_t pickSource(
        input fwdSource_t sel,
        input word_t      regValue,
        input word_t      exValue,
        input word_t      memValue,
        input word_t      loadValue,
        input word_t      wbValue,
        input word_t      rfValue
    );
        case (sel)
            srcEx:      return exValue;
            srcMem:     return memValue;
            srcMemLoad: return loadValue;
            srcWb:      return wbValue;
            srcRfWrite: return rfValue;
            default:    return regValue;
        endcase
    endfunction

    assign branchOperandA = pickSource(branchSelA, idOperandA, exResult, memResult,
                                       memLoadData, wbResult, rfData);
    assign branchOperandB = pickSource(branchSelB, idOperandB, exResult, memResult,
                                       memLoadData, wbResult, rfData);

    // jump target comes from rs, so operand A is the fallback
    assign jumpTarget = pickSource(jumpSel, idOperandA, exResult, memResult,
                                   memLoadData, wbResult, rfData);

    assign branchForwarded = (branchSelA != srcRegFile) || (branchSelB != srcRegFile);
    assign jumpForwarded   = (jumpSel != srcRegFile);

endmodule

`default_nettype wire

/* logic/forwardUnit.sv */
`timescale 1ns/10ps
`default_nettype none

module forwardUnit
    import forwardPkg::*;
(
    input  logic     CLOCK,
    input  logic     RESET,
    input  regAddr_t exRs,
    input  regAddr_t exRt,
    input  word_t    exOperandA,
    input  word_t    exOperandB,
    input  logic     useImmediate,
    input  logic     isBranch,
    input  logic     isJumpReg,
    input  regAddr_t idRs,
    input  regAddr_t idRt,
    input  word_t    idOperandA,
    input  word_t    idOperandB,
    input  regAddr_t exDest,
    input  logic     exWriteEnable,
    input  word_t    exResult,
    input  regAddr_t memDest,
    input  logic     memWriteEnable,
    input  logic     memIsLoad,
    input  word_t    memResult,
    input  word_t    memLoadData,
    input  regAddr_t wbDest,
    input  logic     wbWriteEnable,
    input  word_t    wbResult,
    input  regAddr_t rfDest,
    input  logic     rfWriteEnable,
    input  word_t    rfData,
    output word_t    exForwardedA,
    output word_t    exForwardedB,
    output logic     exForwarded,
    output word_t    branchOperandA,
    output word_t    branchOperandB,
    output logic     branchForwarded,
    output word_t    jumpTarget,
    output logic     jumpForwarded
);

    fwdSource_t exSelA;
    fwdSource_t exSelB;
    fwdSource_t branchSelA;
    fwdSource_t branchSelB;
    fwdSource_t jumpSel;

    forwardControl forwardControl_inst (
        .exRs(exRs), .exRt(exRt), .useImmediate(useImmediate),
        .isBranch(isBranch), .isJumpReg(isJumpReg), .idRs(idRs), .idRt(idRt),
        .exDest(exDest), .exWriteEnable(exWriteEnable),
        .memDest(memDest), .memWriteEnable(memWriteEnable), .memIsLoad(memIsLoad),
        .wbDest(wbDest), .wbWriteEnable(wbWriteEnable),
        .rfDest(rfDest), .rfWriteEnable(rfWriteEnable),
        .exSelA(exSelA), .exSelB(exSelB),
        .branchSelA(branchSelA), .branchSelB(branchSelB), .jumpSel(jumpSel)
    );

    // registered ALU operands
    exOperandBypass exOperandBypass_inst (
        .CLOCK(CLOCK), .RESET(RESET),
        .exSelA(exSelA), .exSelB(exSelB),
        .exOperandA(exOperandA), .exOperandB(exOperandB),
        .memResult(memResult), .wbResult(wbResult), .rfData(rfData),
        .exForwardedA(exForwardedA), .exForwardedB(exForwardedB),
        .exForwarded(exForwarded)
    );

    // same-cycle branch and jump operands
    idOperandBypass idOperandBypass_inst (
        .branchSelA(branchSelA), .branchSelB(branchSelB), .jumpSel(jumpSel),
        .idOperandA(idOperandA), .idOperandB(idOperandB),
        .exResult(exResult), .memResult(memResult), .memLoadData(memLoadData),
        .wbResult(wbResult), .rfData(rfData),
        .branchOperandA(branchOperandA), .branchOperandB(branchOperandB),
        .jumpTarget(jumpTarget),
        .branchForwarded(branchForwarded), .jumpForwarded(jumpForwarded)
    );

endmodule

`default_nettype wire

/* tb/forwardModel.svh */
`ifndef FORWARD_MODEL_SVH
`define FORWARD_MODEL_SVH

// 16-bit Fibonacci LFSR with taps 16 14 13 11
function automatic logic [15:0] lfsrNext(input logic [15:0] state);
    return {state[14:0], state[15] ^ state[13] ^ state[12] ^ state[10]};
endfunction

// one LFSR step per bit taken
function automatic logic [31:0] randomBits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
        lfsrState = lfsrNext(lfsrState);
        value = {value[30:0], lfsrState[0]};
    end
    return value;
endfunction

// {forwarded, value} for an ALU operand from MEM, WB or RF write
function automatic logic [DataWidth:0] exModel(input regAddr_t r, input word_t regValue);
    if (r == '0) return {1'b0, regValue};
    if (memWriteEnable && memDest == r) return {1'b1, memResult};
    if (wbWriteEnable && wbDest == r) return {1'b1, wbResult};
    if (rfWriteEnable && rfDest == r) return {1'b1, rfData};
    return {1'b0, regValue};
endfunction

// ID operand also sees EX and the load data of a load in MEM
function automatic logic [DataWidth:0] idModel(input regAddr_t r, input word_t regValue);
    if (r == '0) return {1'b0, regValue};
    if (exWriteEnable && exDest == r) return {1'b1, exResult};
    if (memWriteEnable && memDest == r) return {1'b1, memIsLoad ? memLoadData : memResult};
    if (wbWriteEnable && wbDest == r) return {1'b1, wbResult};
    if (rfWriteEnable && rfDest == r) return {1'b1, rfData};
    return {1'b0, regValue};
endfunction

task automatic checkValue(input string name, input logic [31:0] actual,
                          input logic [31:0] expected);
    if (actual !== expected) begin
        $display("** Error: %s is 0x%08h, expected 0x%08h", name, actual, expected);
        $display("RESULT: FAIL");
        $fatal(1, "mismatch on %s", name);
    end
endtask

`endif

/* tb/forwardUnitTb.sv */
`timescale 1ns/10ps
`default_nettype none

module forwardUnitTb
    import forwardPkg::*;
();

    localparam int ResetCycles  = 5;
    localparam int RunCycles    = 2000;

    logic CLOCK, RESET;
    regAddr_t exRs, exRt, idRs, idRt, exDest, memDest, wbDest, rfDest;
    word_t exOperandA, exOperandB, idOperandA, idOperandB;
    word_t exResult, memResult, memLoadData, wbResult, rfData;
    logic useImmediate, isBranch, isJumpReg;
    logic exWriteEnable, memWriteEnable, memIsLoad, wbWriteEnable, rfWriteEnable;
    word_t exForwardedA, exForwardedB, branchOperandA, branchOperandB, jumpTarget;
    logic exForwarded, branchForwarded, jumpForwarded;

    logic [15:0] lfsrState;
    logic [DataWidth:0] expExA, expExB, nextExA, nextExB;
    logic [DataWidth:0] expBranchA, expBranchB, expJump;
    logic expExFlag, nextExFlag;

    `include "forwardModel.svh"

    forwardUnit forwardUnit_inst (
        .CLOCK(CLOCK), .RESET(RESET),
        .exRs(exRs), .exRt(exRt), .exOperandA(exOperandA), .exOperandB(exOperandB),
        .useImmediate(useImmediate), .isBranch(isBranch), .isJumpReg(isJumpReg),
        .idRs(idRs), .idRt(idRt), .idOperandA(idOperandA), .idOperandB(idOperandB),
        .exDest(exDest), .exWriteEnable(exWriteEnable), .exResult(exResult),
        .memDest(memDest), .memWriteEnable(memWriteEnable), .memIsLoad(memIsLoad),
        .memResult(memResult), .memLoadData(memLoadData),
        .wbDest(wbDest), .wbWriteEnable(wbWriteEnable), .wbResult(wbResult),
        .rfDest(rfDest), .rfWriteEnable(rfWriteEnable), .rfData(rfData),
        .exForwardedA(exForwardedA), .exForwardedB(exForwardedB),
        .exForwarded(exForwarded),
        .branchOperandA(branchOperandA), .branchOperandB(branchOperandB),
        .branchForwarded(branchForwarded),
        .jumpTarget(jumpTarget), .jumpForwarded(jumpForwarded)
    );

    always #5 CLOCK = ~CLOCK;

    // 2-bit register numbers so matches and r0 show up often
    task automatic driveRandomInputs();
        exRs = regAddr_t'(randomBits(2));
        exRt = regAddr_t'(randomBits(2));
        idRs = regAddr_t'(randomBits(2));
        idRt = regAddr_t'(randomBits(2));
        exDest = regAddr_t'(randomBits(2));
        memDest = regAddr_t'(randomBits(2));
        wbDest = regAddr_t'(randomBits(2));
        rfDest = regAddr_t'(randomBits(2));
        exOperandA = randomBits(32);
        exOperandB = randomBits(32);
        idOperandA = randomBits(32);
        idOperandB = randomBits(32);
        exResult = randomBits(32);
        memResult = randomBits(32);
        memLoadData = randomBits(32);
        wbResult = randomBits(32);
        rfData = randomBits(32);
        useImmediate = 1'(randomBits(1));
        isBranch = 1'(randomBits(1));
        isJumpReg = 1'(randomBits(1));
        exWriteEnable = 1'(randomBits(1));
        memWriteEnable = 1'(randomBits(1));
        memIsLoad = 1'(randomBits(1));
        wbWriteEnable = 1'(randomBits(1));
        rfWriteEnable = 1'(randomBits(1));
    endtask

    initial begin
        CLOCK = 1'b0;
        RESET = 1'b0;
        lfsrState = 16'd64;
        {exRs, exRt, idRs, idRt, exDest, memDest, wbDest, rfDest} = '0;
        {exOperandA, exOperandB, idOperandA, idOperandB} = '0;
        {exResult, memResult, memLoadData, wbResult, rfData} = '0;
        {useImmediate, isBranch, isJumpReg} = '0;
        {exWriteEnable, memWriteEnable, memIsLoad, wbWriteEnable, rfWriteEnable} = '0;

        // random inputs in reset while the registers stay clear
        for (int i = 0; i < ResetCycles; i++) begin
            @(posedge CLOCK);
            #1;
            driveRandomInputs();
        end
        RESET = 1'b1;

        // no EX input sampled out of reset yet
        @(negedge CLOCK);
        checkValue("exForwarded", 32'(exForwarded), 32'd0);
        checkValue("exForwardedA", exForwardedA, 32'd0);
        checkValue("exForwardedB", exForwardedB, 32'd0);

        expExA = exModel(exRs, exOperandA);
        expExB = useImmediate ? {1'b0, exOperandB} : exModel(exRt, exOperandB);
        expExFlag = expExA[DataWidth] | expExB[DataWidth];

        for (int cycle = 0; cycle < RunCycles; cycle++) begin
            @(posedge CLOCK);
            #1;
            driveRandomInputs();
            nextExA = exModel(exRs, exOperandA);
            nextExB = useImmediate ? {1'b0, exOperandB} : exModel(exRt, exOperandB);
            nextExFlag = nextExA[DataWidth] | nextExB[DataWidth];
            expBranchA = isBranch ? idModel(idRs, idOperandA) : {1'b0, idOperandA};
            expBranchB = isBranch ? idModel(idRt, idOperandB) : {1'b0, idOperandB};
            expJump = isJumpReg ? idModel(idRs, idOperandA) : {1'b0, idOperandA};

            // outputs settled by mid-cycle
            @(negedge CLOCK);
            checkValue("exForwardedA", exForwardedA, expExA[DataWidth-1:0]);
            checkValue("exForwardedB", exForwardedB, expExB[DataWidth-1:0]);
            checkValue("exForwarded", 32'(exForwarded), 32'(expExFlag));
            checkValue("branchOperandA", branchOperandA, expBranchA[DataWidth-1:0]);
            checkValue("branchOperandB", branchOperandB, expBranchB[DataWidth-1:0]);
            checkValue("branchForwarded", 32'(branchForwarded),
                       32'(expBranchA[DataWidth] | expBranchB[DataWidth]));
            checkValue("jumpTarget", jumpTarget, expJump[DataWidth-1:0]);
            checkValue("jumpForwarded", 32'(jumpForwarded), 32'(expJump[DataWidth]));
            expExA = nextExA;
            expExB = nextExB;
            expExFlag = nextExFlag;
        end

        $display("RESULT: PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* all.f */
+incdir+tb
logic/forwardPkg.sv
logic/forwardControl.sv
logic/exOperandBypass.sv
logic/idOperandBypass.sv
logic/forwardUnit.sv
tb/forwardUnitTb.sv

/* Bender.yml */
package:
  name: forward_unit

sources:
  - logic/forwardPkg.sv
  - logic/forwardControl.sv
  - logic/exOperandBypass.sv
  - logic/idOperandBypass.sv
  - logic/forwardUnit.sv
  - target: simulation
    include_dirs:
      - tb
    files:
      - tb/forwardUnitTb.sv
